//--- all.f
src/aud_pkg.sv
src/aud_recorder.sv
src/aud_player.sv
src/aud_mem_ctrl.sv
src/aud_core.sv
sim/sram_model.sv
sim/tb_aud_core.sv

//--- sim/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model import aud_pkg::*; (
    input  logic                i_clk,
    input  logic [ADDR_W-1:0]   i_addr,
    input  logic [SAMPLE_W-1:0] i_wdata,
    input  logic                i_we_n,
    output logic [SAMPLE_W-1:0] o_rdata
);

    logic [SAMPLE_W-1:0] mem [0:(2**ADDR_W)-1];

    // Write lands on the clock edge while we_n is low.
    always @(posedge i_clk) begin
        if (!i_we_n) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // Read is combinational from the address pins.
    assign o_rdata = mem[i_addr];

    // Lets the testbench inspect stored words.
    function automatic logic [SAMPLE_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        return mem[addr];
    endfunction

endmodule

`default_nettype wire

//--- sim/tb_aud_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_aud_core import aud_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                lrc;
    logic                adc_data;
    logic                start;
    logic                play;
    logic                pause;
    logic                stop;
    logic                dac_data;
    logic [ADDR_W-1:0]   sram_addr;
    logic [SAMPLE_W-1:0] sram_wdata;
    logic                sram_we_n;
    logic [SAMPLE_W-1:0] sram_rdata;
    aud_mode_e           mode;
    logic                busy;
    logic [ADDR_W-1:0]   rec_len;

    logic [ADDR_W-1:0]   wr_count;
    logic [SAMPLE_W-1:0] rec_q[$];
    logic [SAMPLE_W-1:0] dac_q[$];
    logic [SAMPLE_W-1:0] exp_q[$];
    integer              seed;
    integer              err_count;
    integer              timeout_count;

    aud_core u_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_lrc        (lrc),
        .i_adc_data   (adc_data),
        .i_start      (start),
        .i_play       (play),
        .i_pause      (pause),
        .i_stop       (stop),
        .o_dac_data   (dac_data),
        .o_sram_addr  (sram_addr),
        .o_sram_wdata (sram_wdata),
        .o_sram_we_n  (sram_we_n),
        .i_sram_rdata (sram_rdata),
        .o_mode       (mode),
        .o_busy       (busy),
        .o_rec_len    (rec_len)
    );

    sram_model u_sram (
        .i_clk   (clk),
        .i_addr  (sram_addr),
        .i_wdata (sram_wdata),
        .i_we_n  (sram_we_n),
        .o_rdata (sram_rdata)
    );

    always #4 clk = ~clk;

    // Counts every SRAM write strobe.
    always @(posedge clk) begin
        if (rst_n) begin
            wr_count <= '0;
        end else if (!sram_we_n) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    task automatic check_sample(input logic [SAMPLE_W-1:0] got,
                                input logic [SAMPLE_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_addr(input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_mode(input aud_mode_e got, input aud_mode_e exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got mode %0d expected %0d", $time, what, got, exp);
            err_count = err_count + 1;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %b expected %b", $time, what, got, exp);
            err_count = err_count + 1;
        end
    endtask

    // Left half of 16 bits MSB first, then a right half of 4 cycles.
    task automatic send_frame(input logic [SAMPLE_W-1:0] smp);
        integer rnd;
        for (int i = SAMPLE_W - 1; i >= 0; i--) begin
            @(posedge clk);
            lrc      <= 1'b0;
            adc_data <= smp[i];
        end
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            @(posedge clk);
            lrc      <= 1'b1;
            adc_data <= rnd[0];
        end
    endtask

    task automatic capture_frame(output logic [SAMPLE_W-1:0] left,
                                 output logic [SAMPLE_W-1:0] right);
        integer cnt;
        cnt   = 0;
        left  = '0;
        right = '0;
        @(negedge clk);
        while (lrc && cnt < 64) begin
            @(negedge clk);
            cnt = cnt + 1;
        end
        if (lrc) begin
            $display("Timeout at %0t ns: the left half of the frame never started", $time);
            timeout_count = timeout_count + 1;
        end
        left = {left[SAMPLE_W-2:0], dac_data};
        for (int i = 1; i < SAMPLE_W; i++) begin
            @(negedge clk);
            left = {left[SAMPLE_W-2:0], dac_data};
        end
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            right = {right[SAMPLE_W-2:0], dac_data};
        end
    endtask

    task automatic run_frame(input logic [SAMPLE_W-1:0] smp,
                             output logic [SAMPLE_W-1:0] left,
                             output logic [SAMPLE_W-1:0] right);
        fork
            send_frame(smp);
            capture_frame(left, right);
        join
    endtask

    // ADC frames while the player is idle, so the DAC must stay silent.
    task automatic adc_frames(input int n, input logic keep);
        integer              rnd;
        logic [SAMPLE_W-1:0] smp;
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            smp = rnd[SAMPLE_W-1:0];
            run_frame(smp, left, right);
            if (keep) begin
                rec_q.push_back(smp);
            end
            check_sample(left, '0, "DAC left half while not playing");
            check_sample(right, '0, "DAC right half while not playing");
        end
    endtask

    task automatic dac_frames(input int n);
        integer              rnd;
        logic [SAMPLE_W-1:0] left;
        logic [SAMPLE_W-1:0] right;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            run_frame(rnd[SAMPLE_W-1:0], left, right);
            dac_q.push_back(left);
            check_sample(right, '0, "DAC right half during playback");
        end
    endtask

    task automatic press_start(input logic play_lvl);
        @(posedge clk);
        start <= 1'b1;
        play  <= play_lvl;
        @(posedge clk);
        start <= 1'b0;
        play  <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic press_pause();
        @(posedge clk);
        pause <= 1'b1;
        @(posedge clk);
        pause <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic press_stop();
        @(posedge clk);
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_idle();
        integer cnt;
        cnt = 0;
        while (busy && cnt < 200) begin
            @(negedge clk);
            cnt = cnt + 1;
        end
        if (busy) begin
            $display("Timeout at %0t ns: o_busy did not fall within 200 cycles", $time);
            timeout_count = timeout_count + 1;
        end
    endtask

    task automatic check_sram();
        for (int i = 0; i < rec_q.size(); i++) begin
            check_sample(u_sram.read_word(ADDR_W'(i)), rec_q[i], $sformatf("SRAM word %0d", i));
        end
    endtask

    task automatic compare_dac();
        check_addr(ADDR_W'(dac_q.size()), ADDR_W'(exp_q.size()), "played frame count");
        for (int i = 0; i < dac_q.size() && i < exp_q.size(); i++) begin
            check_sample(dac_q[i], exp_q[i], $sformatf("DAC left half of frame %0d", i));
        end
    endtask

    task automatic test_reset_idle();
        logic [ADDR_W-1:0] base;
        check_mode(mode, MODE_IDLE, "mode after reset");
        check_flag(busy, 1'b0, "busy after reset");
        base = wr_count;
        adc_frames(3, 1'b0);
        check_addr(wr_count - base, '0, "SRAM writes while idle");
    endtask

    task automatic test_record();
        logic [ADDR_W-1:0] base;
        rec_q.delete();
        base = wr_count;
        press_start(1'b0);
        check_mode(mode, MODE_REC, "mode after record start");
        check_flag(busy, 1'b1, "busy while recording");
        adc_frames(5, 1'b1);
        // A play start while recording must be dropped.
        press_start(1'b1);
        check_mode(mode, MODE_REC, "mode after start during recording");
        adc_frames(5, 1'b1);
        press_stop();
        wait_idle();
        check_addr(rec_len, ADDR_W'(10), "recording length");
        check_addr(wr_count - base, ADDR_W'(10), "SRAM writes in recording");
        check_sram();
    endtask

    task automatic test_record_pause();
        rec_q.delete();
        press_start(1'b0);
        adc_frames(3, 1'b1);
        press_pause();
        adc_frames(4, 1'b0);
        press_pause();
        adc_frames(3, 1'b1);
        press_stop();
        wait_idle();
        check_addr(rec_len, ADDR_W'(6), "paused recording length");
        check_sram();
    endtask

    task automatic test_playback();
        dac_q.delete();
        exp_q.delete();
        // One frame of latency before the first word.
        exp_q.push_back('0);
        for (int i = 0; i < rec_q.size(); i++) begin
            exp_q.push_back(rec_q[i]);
        end
        press_start(1'b1);
        check_mode(mode, MODE_PLAY, "mode after play start");
        check_flag(busy, 1'b1, "busy while playing");
        dac_frames(rec_q.size());
        check_mode(mode, MODE_PLAY, "mode before last word");
        dac_frames(1);
        wait_idle();
        compare_dac();
    endtask

    task automatic test_play_pause();
        dac_q.delete();
        exp_q.delete();
        exp_q.push_back('0);
        for (int i = 0; i < 3; i++) begin
            exp_q.push_back(rec_q[i]);
        end
        // Paused frame, then the frame that reloads after resume.
        exp_q.push_back('0);
        exp_q.push_back('0);
        for (int i = 3; i < rec_q.size(); i++) begin
            exp_q.push_back(rec_q[i]);
        end
        press_start(1'b1);
        dac_frames(3);
        press_pause();
        dac_frames(2);
        press_pause();
        dac_frames(rec_q.size() - 2);
        wait_idle();
        compare_dac();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b1;
        lrc           = 1'b1;
        adc_data      = 1'b0;
        start         = 1'b0;
        play          = 1'b0;
        pause         = 1'b0;
        stop          = 1'b0;
        seed          = 32'hc570_731f;
        err_count     = 0;
        timeout_count = 0;

        repeat (8) @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);

        test_reset_idle();
        test_record();
        test_record_pause();
        test_playback();
        test_play_pause();

        $display("Check errors: %0d, timeouts: %0d", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/aud_core.sv
`timescale 1ns/1ns
`default_nettype none

module aud_core import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_adc_data,
    input  logic                i_start,
    input  logic                i_play,
    input  logic                i_pause,
    input  logic                i_stop,
    output logic                o_dac_data,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    output logic                o_sram_we_n,
    input  logic [SAMPLE_W-1:0] i_sram_rdata,
    output aud_mode_e           o_mode,
    output logic                o_busy,
    output logic [ADDR_W-1:0]   o_rec_len
);

    logic                rec_start, rec_pause, rec_stop;
    logic                play_start, play_pause, play_stop;
    logic                rec_wr_en;
    logic [ADDR_W-1:0]   rec_addr;
    logic [SAMPLE_W-1:0] rec_data;
    logic                rec_done;
    logic [ADDR_W-1:0]   rec_len;
    logic [ADDR_W-1:0]   play_addr;
    logic                play_done;
    aud_mode_e           mode;

    aud_recorder u_recorder (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_lrc     (i_lrc),
        .i_data    (i_adc_data),
        .i_start   (rec_start),
        .i_pause   (rec_pause),
        .i_stop    (rec_stop),
        .o_wr_en   (rec_wr_en),
        .o_wr_addr (rec_addr),
        .o_wr_data (rec_data),
        .o_done    (rec_done),
        .o_len     (rec_len)
    );

    // Read data comes straight from the SRAM pins.
    aud_player u_player (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_lrc      (i_lrc),
        .i_start    (play_start),
        .i_pause    (play_pause),
        .i_stop     (play_stop),
        .i_len      (o_rec_len),
        .i_rd_data  (i_sram_rdata),
        .o_rd_addr  (play_addr),
        .o_dac_data (o_dac_data),
        .o_done     (play_done)
    );

    aud_mem_ctrl u_mem_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_play       (i_play),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .o_rec_start  (rec_start),
        .o_rec_pause  (rec_pause),
        .o_rec_stop   (rec_stop),
        .o_play_start (play_start),
        .o_play_pause (play_pause),
        .o_play_stop  (play_stop),
        .i_rec_wr_en  (rec_wr_en),
        .i_rec_addr   (rec_addr),
        .i_rec_data   (rec_data),
        .i_rec_done   (rec_done),
        .i_rec_len    (rec_len),
        .i_play_addr  (play_addr),
        .i_play_done  (play_done),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wdata (o_sram_wdata),
        .o_sram_we_n  (o_sram_we_n),
        .o_len        (o_rec_len),
        .o_mode       (mode)
    );

    assign o_mode = mode;
    assign o_busy = (mode != MODE_IDLE);

endmodule

`default_nettype wire

//--- src/aud_mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module aud_mem_ctrl import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_start,
    input  logic                i_play,
    input  logic                i_pause,
    input  logic                i_stop,
    output logic                o_rec_start,
    output logic                o_rec_pause,
    output logic                o_rec_stop,
    output logic                o_play_start,
    output logic                o_play_pause,
    output logic                o_play_stop,
    input  logic                i_rec_wr_en,
    input  logic [ADDR_W-1:0]   i_rec_addr,
    input  logic [SAMPLE_W-1:0] i_rec_data,
    input  logic                i_rec_done,
    input  logic [ADDR_W-1:0]   i_rec_len,
    input  logic [ADDR_W-1:0]   i_play_addr,
    input  logic                i_play_done,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_wdata,
    output logic                o_sram_we_n,
    output logic [ADDR_W-1:0]   o_len,
    output aud_mode_e           o_mode
);

    aud_mode_e         mode_r, mode_w;
    logic [ADDR_W-1:0] len_r;
    logic              rec_sel;
    logic              play_sel;
    logic              idle;

    assign idle     = (mode_r == MODE_IDLE);
    assign rec_sel  = (mode_r == MODE_REC);
    assign play_sel = (mode_r == MODE_PLAY);

    always_comb begin
        mode_w = mode_r;
        case (mode_r)
            MODE_IDLE: begin
                if (i_start) begin
                    mode_w = i_play ? MODE_PLAY : MODE_REC;
                end
            end
            MODE_REC: begin
                if (i_rec_done) begin
                    mode_w = MODE_IDLE;
                end
            end
            MODE_PLAY: begin
                if (i_play_done) begin
                    mode_w = MODE_IDLE;
                end
            end
            default: mode_w = MODE_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            mode_r       <= MODE_IDLE;
            len_r        <= '0;
            o_rec_start  <= 1'b0;
            o_rec_pause  <= 1'b0;
            o_rec_stop   <= 1'b0;
            o_play_start <= 1'b0;
            o_play_pause <= 1'b0;
            o_play_stop  <= 1'b0;
        end else begin
            mode_r       <= mode_w;
            // Commands reach only the engine that owns the mode.
            o_rec_start  <= i_start && idle && !i_play;
            o_rec_pause  <= i_pause && rec_sel;
            o_rec_stop   <= i_stop && rec_sel;
            o_play_start <= i_start && idle && i_play;
            o_play_pause <= i_pause && play_sel;
            o_play_stop  <= i_stop && play_sel;
            if (rec_sel && i_rec_done) begin
                len_r <= i_rec_len;
            end
        end
    end

    // Single SRAM port shared by mode.
    assign o_sram_addr  = play_sel ? i_play_addr : i_rec_addr;
    assign o_sram_wdata = rec_sel ? i_rec_data : '0;
    assign o_sram_we_n  = ~(rec_sel & i_rec_wr_en);

    assign o_len  = len_r;
    assign o_mode = mode_r;

endmodule

`default_nettype wire

//--- src/aud_pkg.sv
`default_nettype none

package aud_pkg;

    // SRAM word address width.
    localparam int ADDR_W = 20;

    // Bits per audio sample.
    localparam int SAMPLE_W = 16;

    // Words a recording may hold before it stops by itself.
    localparam int MEM_WORDS = 1024000;

    // Bit counter width that can hold SAMPLE_W itself.
    localparam int CNT_W = $clog2(SAMPLE_W) + 1;

    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_REC  = 2'd1,
        MODE_PLAY = 2'd2
    } aud_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_WAIT_LEFT = 3'd1,
        ST_SHIFT     = 3'd2,
        ST_PAUSE     = 3'd3,
        ST_FINISH    = 3'd4
    } eng_state_e;

endpackage

`default_nettype wire

//--- src/aud_player.sv
`timescale 1ns/1ns
`default_nettype none

module aud_player import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_start,
    input  logic                i_pause,
    input  logic                i_stop,
    input  logic [ADDR_W-1:0]   i_len,
    input  logic [SAMPLE_W-1:0] i_rd_data,
    output logic [ADDR_W-1:0]   o_rd_addr,
    output logic                o_dac_data,
    output logic                o_done
);

    eng_state_e           state_r, state_w;
    logic [CNT_W-1:0]     cnt_r, cnt_w;
    logic [ADDR_W-1:0]    addr_r, addr_w;
    logic [SAMPLE_W-1:0]  shift_r;
    logic                 pause_r, pause_w;
    logic                 stop_r, stop_w;
    logic                 done_r, done_w;
    logic                 lrc_q;
    logic                 lrc_rise;
    logic                 load;
    logic                 shift_en;

    assign lrc_rise = i_lrc & ~lrc_q;

    always_comb begin
        state_w  = state_r;
        cnt_w    = cnt_r;
        addr_w   = addr_r;
        pause_w  = pause_r;
        stop_w   = stop_r;
        done_w   = 1'b0;
        load     = 1'b0;
        shift_en = 1'b0;

        if (state_r != ST_IDLE && state_r != ST_FINISH) begin
            if (i_pause) begin
                pause_w = ~pause_r;
            end
            if (i_stop) begin
                stop_w = 1'b1;
            end
        end

        case (state_r)
            ST_IDLE: begin
                if (i_start) begin
                    addr_w  = '0;
                    pause_w = 1'b0;
                    stop_w  = 1'b0;
                    state_w = (i_len == '0) ? ST_FINISH : ST_WAIT_LEFT;
                end
            end
            ST_WAIT_LEFT: begin
                if (stop_r) begin
                    state_w = ST_FINISH;
                end else if (lrc_rise) begin
                    if (pause_r) begin
                        state_w = ST_PAUSE;
                    end else begin
                        load    = 1'b1;
                        addr_w  = addr_r + 1'b1;
                        cnt_w   = '0;
                        state_w = ST_SHIFT;
                    end
                end
            end
            ST_SHIFT: begin
                if (!i_lrc && cnt_r != CNT_W'(SAMPLE_W)) begin
                    shift_en = 1'b1;
                    cnt_w    = cnt_r + 1'b1;
                    // Last bit of the last word, or a pending stop.
                    if (cnt_r == CNT_W'(SAMPLE_W - 1) && (addr_r == i_len || stop_r)) begin
                        state_w = ST_FINISH;
                    end
                end else if (lrc_rise) begin
                    if (stop_r) begin
                        state_w = ST_FINISH;
                    end else if (pause_r) begin
                        state_w = ST_PAUSE;
                    end else begin
                        load   = 1'b1;
                        addr_w = addr_r + 1'b1;
                        cnt_w  = '0;
                    end
                end
            end
            ST_PAUSE: begin
                if (stop_r) begin
                    state_w = ST_FINISH;
                end else if (!pause_r) begin
                    state_w = ST_WAIT_LEFT;
                end
            end
            ST_FINISH: begin
                done_w  = 1'b1;
                state_w = ST_IDLE;
            end
            default: state_w = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= ST_IDLE;
            cnt_r   <= '0;
            addr_r  <= '0;
            pause_r <= 1'b0;
            stop_r  <= 1'b0;
            done_r  <= 1'b0;
            lrc_q   <= 1'b0;
        end else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            addr_r  <= addr_w;
            pause_r <= pause_w;
            stop_r  <= stop_w;
            done_r  <= done_w;
            lrc_q   <= i_lrc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            shift_r <= i_rd_data;
        end else if (shift_en) begin
            shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
        end
    end

    // Silent in the right half and after the sixteenth bit.
    assign o_dac_data = (state_r == ST_SHIFT) && !i_lrc && (cnt_r != CNT_W'(SAMPLE_W))
                        && shift_r[SAMPLE_W-1];
    assign o_rd_addr  = addr_r;
    assign o_done     = done_r;

endmodule

`default_nettype wire

//--- src/aud_recorder.sv
`timescale 1ns/1ns
`default_nettype none

module aud_recorder import aud_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_data,
    input  logic                i_start,
    input  logic                i_pause,
    input  logic                i_stop,
    output logic                o_wr_en,
    output logic [ADDR_W-1:0]   o_wr_addr,
    output logic [SAMPLE_W-1:0] o_wr_data,
    output logic                o_done,
    output logic [ADDR_W-1:0]   o_len
);

    eng_state_e           state_r, state_w;
    logic [CNT_W-1:0]     cnt_r, cnt_w;
    logic [ADDR_W-1:0]    addr_r, addr_w;
    logic [SAMPLE_W-1:0]  shift_r;
    logic                 pause_r, pause_w;
    logic                 stop_r, stop_w;
    logic                 wr_en_r, wr_en_w;
    logic                 done_r, done_w;
    logic                 lrc_q;
    logic                 lrc_fall;
    logic                 shift_en;

    // First cycle of the left half.
    assign lrc_fall = lrc_q & ~i_lrc;

    always_comb begin
        state_w  = state_r;
        cnt_w    = cnt_r;
        addr_w   = addr_r;
        pause_w  = pause_r;
        stop_w   = stop_r;
        wr_en_w  = 1'b0;
        done_w   = 1'b0;
        shift_en = 1'b0;

        // Address moves on once the word has gone out.
        if (wr_en_r) begin
            addr_w = addr_r + 1'b1;
        end

        if (state_r != ST_IDLE && state_r != ST_FINISH) begin
            if (i_pause) begin
                pause_w = ~pause_r;
            end
            if (i_stop) begin
                stop_w = 1'b1;
            end
        end

        case (state_r)
            ST_IDLE: begin
                if (i_start) begin
                    addr_w  = '0;
                    cnt_w   = '0;
                    pause_w = 1'b0;
                    stop_w  = 1'b0;
                    state_w = ST_WAIT_LEFT;
                end
            end
            ST_WAIT_LEFT: begin
                // Pending commands apply at the frame boundary.
                if (stop_r) begin
                    state_w = ST_FINISH;
                end else if (pause_r) begin
                    state_w = ST_PAUSE;
                end else if (lrc_fall) begin
                    shift_en = 1'b1;
                    cnt_w    = CNT_W'(1);
                    state_w  = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                shift_en = 1'b1;
                if (cnt_r == CNT_W'(SAMPLE_W - 1)) begin
                    wr_en_w = 1'b1;
                    cnt_w   = '0;
                    if (addr_r == ADDR_W'(MEM_WORDS - 1)) begin
                        state_w = ST_FINISH;
                    end else begin
                        state_w = ST_WAIT_LEFT;
                    end
                end else begin
                    cnt_w = cnt_r + 1'b1;
                end
            end
            ST_PAUSE: begin
                if (stop_r) begin
                    state_w = ST_FINISH;
                end else if (!pause_r) begin
                    state_w = ST_WAIT_LEFT;
                end
            end
            ST_FINISH: begin
                done_w  = 1'b1;
                state_w = ST_IDLE;
            end
            default: state_w = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= ST_IDLE;
            cnt_r   <= '0;
            addr_r  <= '0;
            pause_r <= 1'b0;
            stop_r  <= 1'b0;
            wr_en_r <= 1'b0;
            done_r  <= 1'b0;
            lrc_q   <= 1'b0;
        end else begin
            state_r <= state_w;
            cnt_r   <= cnt_w;
            addr_r  <= addr_w;
            pause_r <= pause_w;
            stop_r  <= stop_w;
            wr_en_r <= wr_en_w;
            done_r  <= done_w;
            lrc_q   <= i_lrc;
        end
    end

    // MSB arrives first.
    always_ff @(posedge i_clk) begin
        if (shift_en) begin
            shift_r <= {shift_r[SAMPLE_W-2:0], i_data};
        end
    end

    assign o_wr_en   = wr_en_r;
    assign o_wr_addr = addr_r;
    assign o_wr_data = shift_r;
    assign o_done    = done_r;
    assign o_len     = addr_r;

endmodule

`default_nettype wire
